// File: design/eth_rx_config.svh
`ifndef ETH_RX_CONFIG_SVH
`define ETH_RX_CONFIG_SVH

// Datapath geometry, fixed at one 64-bit XGMII word
`define ETH_RX_DATA_W 64
`define ETH_RX_LANES 8

// XGMII control characters
`define XGMII_START 8'hFB
`define XGMII_TERM 8'hFD
`define XGMII_IDLE 8'h07

// Ethernet CRC-32 starts from all ones
`define ETH_CRC_SEED 32'hFFFF_FFFF

`endif

// File: design/eth_rx_pkg.sv
`default_nettype none

`include "eth_rx_config.svh"

package eth_rx_pkg;

    typedef logic [`ETH_RX_DATA_W-1:0] xgmii_word_t;
    typedef logic [`ETH_RX_LANES-1:0] lane_mask_t;
    typedef logic [31:0] crc_t;

    // One word from the PHY with its per-lane control flags
    typedef struct packed {
        xgmii_word_t data;
        lane_mask_t  ctrl;
        logic        valid;
    } xgmii_beat_t;

    // Output frame beat, user carries the FCS result on the last beat
    typedef struct packed {
        xgmii_word_t data;
        lane_mask_t  keep;
        logic        valid;
        logic        last;
        logic        user;
    } axis_beat_t;

    // Start and terminate positions found in the current word
    typedef struct packed {
        logic       start_0;
        logic       start_4;
        logic       term_found;
        lane_mask_t term_mask;
    } lane_info_t;

    typedef enum logic {
        IDLE = 1'b0,
        DATA = 1'b1
    } rx_state_t;

endpackage

`default_nettype wire

// File: design/xgmii_lane_decoder.sv
`default_nettype none
`timescale 1ns/10ps

`include "eth_rx_config.svh"

module xgmii_lane_decoder (
    input  wire eth_rx_pkg::xgmii_beat_t i_xgmii,
    output eth_rx_pkg::lane_info_t       o_lanes
);

    eth_rx_pkg::lane_mask_t term_hits;

    // Terminate may sit in any lane
    always_comb begin
        for (int i = 0; i < `ETH_RX_LANES; i++) begin
            term_hits[i] = i_xgmii.ctrl[i] && (i_xgmii.data[i*8 +: 8] == `XGMII_TERM);
        end
    end

    always_comb begin
        // Start is only legal on a 4-byte boundary
        o_lanes.start_0 = i_xgmii.valid && i_xgmii.ctrl[0]
                          && (i_xgmii.data[7:0] == `XGMII_START);
        o_lanes.start_4 = i_xgmii.valid && i_xgmii.ctrl[4]
                          && (i_xgmii.data[39:32] == `XGMII_START);

        // Nothing is reported while the PHY strobe is low
        o_lanes.term_mask  = i_xgmii.valid ? term_hits : '0;
        o_lanes.term_found = i_xgmii.valid && (|term_hits);
    end

    // Keep mask and FCS position both assume a single terminate per word
    always_comb begin
        if (i_xgmii.valid) begin
            assert ($onehot0(term_hits))
                else $error("xgmii_lane_decoder: more than one terminate in a word");
        end
    end

endmodule

`default_nettype wire

// File: design/rx_frame_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module rx_frame_ctrl (
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire                         i_rx_valid,
    input  wire eth_rx_pkg::lane_info_t i_lanes,
    output logic                        o_beat_valid,
    output logic                        o_last,
    output logic                        o_frame_active,
    output eth_rx_pkg::lane_mask_t      o_keep
);

    eth_rx_pkg::rx_state_t  state;
    eth_rx_pkg::rx_state_t  state_next;
    logic                   start_seen;
    logic                   start_lane4;
    logic                   first_beat;
    eth_rx_pkg::lane_mask_t base_keep;
    eth_rx_pkg::lane_mask_t term_keep;

    assign start_seen = i_lanes.start_0 || i_lanes.start_4;

    always_comb begin
        state_next = state;
        case (state)
            eth_rx_pkg::IDLE: begin
                if (start_seen) begin
                    state_next = eth_rx_pkg::DATA;
                end
            end
            eth_rx_pkg::DATA: begin
                if (i_lanes.term_found) begin
                    state_next = eth_rx_pkg::IDLE;
                end
            end
            default: state_next = eth_rx_pkg::IDLE;
        endcase
    end

    // Everything holds while the PHY strobe is low
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= eth_rx_pkg::IDLE;
            start_lane4 <= 1'b0;
            first_beat  <= 1'b0;
        end else if (i_rx_valid) begin
            state <= state_next;
            if (state == eth_rx_pkg::IDLE && start_seen) begin
                start_lane4 <= i_lanes.start_4;
                first_beat  <= 1'b1;
            end else begin
                first_beat <= 1'b0;
            end
        end
    end

    // A lane 4 start leaves only the upper half of the next word as payload
    assign base_keep = (first_beat && start_lane4) ? 8'hF0 : 8'hFF;

    // One-hot terminate minus one marks every lane below it
    assign term_keep = i_lanes.term_mask - 8'd1;

    assign o_frame_active = (state == eth_rx_pkg::DATA);
    assign o_beat_valid   = o_frame_active && i_rx_valid;
    assign o_last         = o_beat_valid && i_lanes.term_found;
    assign o_keep         = !o_frame_active    ? '0 :
                            i_lanes.term_found ? (base_keep & term_keep) : base_keep;

    // A start inside an open frame is never picked up, even next to its terminate
    assert property (@(posedge i_clk) disable iff (i_reset)
        o_frame_active |-> !start_seen)
        else $error("rx_frame_ctrl: start character inside an open frame");

endmodule

`default_nettype wire

// File: design/rx_byte_masker.sv
`default_nettype none
`timescale 1ns/10ps

`include "eth_rx_config.svh"

module rx_byte_masker (
    input  wire eth_rx_pkg::xgmii_beat_t i_xgmii,
    input  wire                          i_beat_valid,
    input  wire                          i_last,
    input  wire eth_rx_pkg::lane_mask_t  i_keep,
    input  wire                          i_fcs_good,
    output eth_rx_pkg::axis_beat_t       o_axis
);

    eth_rx_pkg::xgmii_word_t masked_data;

    // Preamble, SFD, terminate and idle bytes read as zero
    always_comb begin
        for (int i = 0; i < `ETH_RX_LANES; i++) begin
            masked_data[i*8 +: 8] = i_keep[i] ? i_xgmii.data[i*8 +: 8] : 8'h00;
        end
    end

    always_comb begin
        o_axis.data  = masked_data;
        o_axis.keep  = i_keep;
        o_axis.valid = i_beat_valid;
        o_axis.last  = i_last;
        o_axis.user  = i_fcs_good;
    end

endmodule

`default_nettype wire

// File: design/crc32_slice8.sv
`default_nettype none
`timescale 1ns/10ps

`include "eth_rx_config.svh"

module crc32_slice8 (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire                          i_clear,
    input  wire eth_rx_pkg::xgmii_word_t i_data,
    input  wire eth_rx_pkg::lane_mask_t  i_byte_en,
    output eth_rx_pkg::crc_t             o_crc
);

    // Reflected form of the Ethernet polynomial 04C11DB7
    localparam eth_rx_pkg::crc_t CRC_POLY = 32'hEDB8_8320;

    eth_rx_pkg::crc_t crc_q;
    eth_rx_pkg::crc_t crc_next;

    // One byte through the reflected CRC, LSB first as on the wire
    function automatic eth_rx_pkg::crc_t crc_byte(
        input eth_rx_pkg::crc_t crc_in,
        input logic [7:0]       data_byte
    );
        eth_rx_pkg::crc_t c;
        c = crc_in ^ {24'h0, data_byte};
        for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // Chain of byte slices, lane 0 first
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < `ETH_RX_LANES; i++) begin
            if (i_byte_en[i]) begin
                crc_next = crc_byte(crc_next, i_data[i*8 +: 8]);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || i_clear) begin
            crc_q <= `ETH_CRC_SEED;
        end else begin
            crc_q <= crc_next;
        end
    end

    // Result already folds this word in, ready to compare with a received FCS
    assign o_crc = ~crc_next;

    // Enabled bytes form one run from lane 0 so slice order matches byte order
    assert property (@(posedge i_clk) disable iff (i_reset)
        (i_byte_en & (i_byte_en + 8'd1)) == 8'd0)
        else $error("crc32_slice8: byte enables not contiguous from lane 0");

endmodule

`default_nettype wire

// File: design/rx_fcs_check.sv
`default_nettype none
`timescale 1ns/10ps

module rx_fcs_check (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire eth_rx_pkg::xgmii_beat_t i_xgmii,
    input  wire eth_rx_pkg::lane_info_t  i_lanes,
    input  wire                          i_beat_valid,
    input  wire                          i_frame_active,
    input  wire eth_rx_pkg::lane_mask_t  i_keep,
    output logic                         o_fcs_good
);

    eth_rx_pkg::lane_mask_t  beat_en;
    logic                    align;
    logic                    term_hi;
    logic                    term_last;
    eth_rx_pkg::xgmii_word_t crc_data;
    eth_rx_pkg::lane_mask_t  crc_en;
    eth_rx_pkg::xgmii_word_t prev_data;
    eth_rx_pkg::lane_mask_t  prev_en;
    eth_rx_pkg::lane_mask_t  del_en;
    eth_rx_pkg::crc_t        prev_hi;
    logic [2:0]              term_idx;
    logic [95:0]             fcs_window;
    eth_rx_pkg::crc_t        rx_fcs;
    eth_rx_pkg::crc_t        crc_direct;
    eth_rx_pkg::crc_t        crc_delayed;
    eth_rx_pkg::crc_t        sel_crc;

    assign beat_en   = i_beat_valid ? i_keep : '0;
    assign term_hi   = |i_lanes.term_mask[7:4];
    assign term_last = i_beat_valid && i_lanes.term_found;

    // A lane 4 start is shifted down so the CRC sees bytes from lane 0
    assign align = !beat_en[0];

    always_comb begin
        crc_data = align ? {32'h0, i_xgmii.data[63:32]} : i_xgmii.data;
        crc_en   = align ? {4'h0, beat_en[7:4]} : beat_en;
        // On the last beat leave the four FCS bytes out
        if (term_last) begin
            crc_en = term_hi ? ({4'h0, i_lanes.term_mask[7:4]} - 8'd1) : '0;
        end
    end

    // Delayed path replays the previous word, cut short when the FCS straddles
    always_comb begin
        del_en = i_xgmii.valid ? prev_en : '0;
        if (term_last && !term_hi) begin
            del_en = {i_lanes.term_mask[3:0], 4'h0} - 8'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            prev_en <= '0;
        end else if (i_xgmii.valid) begin
            prev_en <= crc_en;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_xgmii.valid) begin
            prev_data <= crc_data;
            prev_hi   <= i_xgmii.data[63:32];
        end
    end

    always_comb begin
        term_idx = 3'd0;
        for (int i = 0; i < 8; i++) begin
            if (i_lanes.term_mask[i]) begin
                term_idx = 3'(i);
            end
        end
    end

    // FCS is the four bytes just below the terminate, possibly reaching into prev_hi
    assign fcs_window = {i_xgmii.data, prev_hi} >> {term_idx, 3'b000};
    assign rx_fcs     = fcs_window[31:0];

    crc32_slice8 crc_direct_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_clear   (!i_frame_active),
        .i_data    (crc_data),
        .i_byte_en (crc_en),
        .o_crc     (crc_direct)
    );

    crc32_slice8 crc_delayed_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_clear   (!i_frame_active),
        .i_data    (prev_data),
        .i_byte_en (del_en),
        .o_crc     (crc_delayed)
    );

    assign sel_crc    = term_hi ? crc_direct : crc_delayed;
    assign o_fcs_good = term_last && (sel_crc == rx_fcs);

    // A split FCS is only rebuilt from a full middle word
    assert property (@(posedge i_clk) disable iff (i_reset)
        (term_last && !term_hi) |-> (prev_en == 8'hFF))
        else $error("rx_fcs_check: split FCS without a full previous word");

endmodule

`default_nettype wire

// File: design/eth_rx_mac.sv
`default_nettype none
`timescale 1ns/10ps

module eth_rx_mac (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire eth_rx_pkg::xgmii_beat_t i_xgmii,
    output eth_rx_pkg::axis_beat_t       o_axis
);

    eth_rx_pkg::lane_info_t lanes;
    eth_rx_pkg::lane_mask_t keep;
    logic                   beat_valid;
    logic                   last;
    logic                   frame_active;
    logic                   fcs_good;

    xgmii_lane_decoder lane_decoder_i (
        .i_xgmii (i_xgmii),
        .o_lanes (lanes)
    );

    rx_frame_ctrl frame_ctrl_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_rx_valid     (i_xgmii.valid),
        .i_lanes        (lanes),
        .o_beat_valid   (beat_valid),
        .o_last         (last),
        .o_frame_active (frame_active),
        .o_keep         (keep)
    );

    rx_byte_masker byte_masker_i (
        .i_xgmii      (i_xgmii),
        .i_beat_valid (beat_valid),
        .i_last       (last),
        .i_keep       (keep),
        .i_fcs_good   (fcs_good),
        .o_axis       (o_axis)
    );

    rx_fcs_check fcs_check_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_xgmii        (i_xgmii),
        .i_lanes        (lanes),
        .i_beat_valid   (beat_valid),
        .i_frame_active (frame_active),
        .i_keep         (keep),
        .o_fcs_good     (fcs_good)
    );

endmodule

`default_nettype wire

// File: dv/eth_rx_checker.sv
`default_nettype none
`timescale 1ns/10ps

module eth_rx_checker (
    input wire                         i_clk,
    input wire                         i_reset,
    input wire eth_rx_pkg::axis_beat_t i_axis
);

    eth_rx_pkg::axis_beat_t expected_q[$];
    eth_rx_pkg::axis_beat_t exp_beat;
    int                     mismatches = 0;
    int                     other_errors = 0;
    int                     beats_checked = 0;

    task automatic push_expected(input eth_rx_pkg::axis_beat_t beat);
        expected_q.push_back(beat);
    endtask

    task automatic compare_field(
        input string       name,
        input logic [63:0] expected,
        input logic [63:0] actual
    );
        if (expected !== actual) begin
            mismatches++;
            $display("mismatch at time %0t: %s expected %0h got %0h",
                     $time, name, expected, actual);
        end
    endtask

    // Outputs settle from the word driven on the falling edge
    always @(posedge i_clk) begin
        if ($isunknown(i_axis.valid)) begin
            other_errors++;
            $display("Error at time %0t: o_axis.valid is unknown", $time);
        end else if (i_axis.valid) begin
            if (i_reset) begin
                other_errors++;
                $display("Error at time %0t: output beat during reset", $time);
            end else if (expected_q.size() == 0) begin
                other_errors++;
                $display("Error at time %0t: output beat arrived when none was expected", $time);
            end else begin
                exp_beat = expected_q.pop_front();
                beats_checked++;
                compare_field("o_axis.data", exp_beat.data, i_axis.data);
                compare_field("o_axis.keep", 64'(exp_beat.keep), 64'(i_axis.keep));
                compare_field("o_axis.last", 64'(exp_beat.last), 64'(i_axis.last));
                compare_field("o_axis.user", 64'(exp_beat.user), 64'(i_axis.user));
            end
        end
    end

    task automatic report_results(output int total);
        if (expected_q.size() != 0) begin
            other_errors += expected_q.size();
            $display("Error: %0d expected beats never appeared", expected_q.size());
        end
        total = mismatches + other_errors;
        $display("Checker: %0d beats checked, %0d mismatches, %0d other errors",
                 beats_checked, mismatches, other_errors);
    endtask

endmodule

`default_nettype wire

// File: dv/eth_rx_tb.sv
`default_nettype none
`timescale 1ns/10ps

`include "eth_rx_config.svh"

module eth_rx_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_FRAMES   = 64;
    localparam int RUN_LIMIT_NS = NUM_FRAMES * 40 * CLK_PERIOD + 200;

    logic                    clk;
    logic                    reset;
    eth_rx_pkg::xgmii_beat_t xgmii;
    eth_rx_pkg::axis_beat_t  axis;
    int                      total_errors;

    // Payload plus FCS of the frame being built, then its XGMII lanes
    logic [7:0] frame_bytes [0:127];
    logic [7:0] lane_data [0:255];
    logic       lane_ctrl [0:255];

    eth_rx_mac eth_rx_mac_i (
        .i_clk   (clk),
        .i_reset (reset),
        .i_xgmii (xgmii),
        .o_axis  (axis)
    );

    eth_rx_checker checker_i (
        .i_clk   (clk),
        .i_reset (reset),
        .i_axis  (axis)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Bit-serial reflected CRC-32 over the first len bytes, result inverted
    function automatic eth_rx_pkg::crc_t fcs_of(input int len);
        eth_rx_pkg::crc_t crc;
        logic             fb;
        crc = `ETH_CRC_SEED;
        for (int i = 0; i < len; i++) begin
            for (int b = 0; b < 8; b++) begin
                fb  = crc[0] ^ frame_bytes[i][b];
                crc = {1'b0, crc[31:1]};
                if (fb) begin
                    crc = crc ^ 32'hEDB8_8320;
                end
            end
        end
        return ~crc;
    endfunction

    function automatic eth_rx_pkg::xgmii_word_t keep_bytes(
        input eth_rx_pkg::xgmii_word_t data,
        input eth_rx_pkg::lane_mask_t  keep
    );
        eth_rx_pkg::xgmii_word_t result;
        result = '0;
        for (int i = 0; i < 8; i++) begin
            if (keep[i]) begin
                result[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic drive_word(
        input eth_rx_pkg::xgmii_word_t data,
        input eth_rx_pkg::lane_mask_t  ctrl
    );
        int pause;
        pause = 0;
        if ($urandom_range(0, 4) == 0) begin
            pause = $urandom_range(1, 3);
        end
        // Junk on the bus while the PHY strobe is low
        for (int p = 0; p < pause; p++) begin
            @(negedge clk);
            xgmii.data  = {$urandom, $urandom};
            xgmii.ctrl  = 8'($urandom);
            xgmii.valid = 1'b0;
        end
        @(negedge clk);
        xgmii.data  = data;
        xgmii.ctrl  = ctrl;
        xgmii.valid = 1'b1;
    endtask

    task automatic send_gap_word();
        eth_rx_pkg::xgmii_word_t data;
        eth_rx_pkg::lane_mask_t  ctrl;
        int                      kind;
        int                      lane;
        kind = $urandom_range(0, 2);
        lane = $urandom_range(0, 7);
        data = {8{`XGMII_IDLE}};
        ctrl = 8'hFF;
        if (kind == 1) begin
            // Lone terminate with no frame open
            data[lane*8 +: 8] = `XGMII_TERM;
        end else if (kind == 2) begin
            data = {$urandom, $urandom};
            ctrl = 8'h00;
        end
        drive_word(data, ctrl);
    endtask

    task automatic send_frame(input int index);
        int                      start_lane;
        int                      term_lane;
        int                      len;
        int                      pos;
        int                      words;
        logic                    good;
        eth_rx_pkg::crc_t        fcs;
        eth_rx_pkg::xgmii_word_t data;
        eth_rx_pkg::lane_mask_t  ctrl;
        eth_rx_pkg::axis_beat_t  beat;

        start_lane = 4 * $urandom_range(0, 1);
        term_lane  = index % 8;
        // Length nudged so the terminate lands in the chosen lane
        len = 14 + 8 * $urandom_range(0, 12);
        len = len + ((term_lane - start_lane - 12 - len) % 8 + 8) % 8;
        for (int i = 0; i < len; i++) begin
            frame_bytes[i] = 8'($urandom);
        end
        fcs = fcs_of(len);
        for (int i = 0; i < 4; i++) begin
            frame_bytes[len + i] = fcs[i*8 +: 8];
        end
        if ($urandom_range(0, 3) == 0) begin
            pos = $urandom_range(0, len + 3);
            frame_bytes[pos] = frame_bytes[pos] ^ (8'd1 << $urandom_range(0, 7));
        end
        good = (fcs_of(len) == {frame_bytes[len + 3], frame_bytes[len + 2],
                                frame_bytes[len + 1], frame_bytes[len]});

        // Start, six preamble bytes, SFD, payload, FCS, terminate, idle fill
        pos   = start_lane + 12 + len;
        words = pos / 8 + 1;
        for (int l = 0; l < words * 8; l++) begin
            lane_data[l] = `XGMII_IDLE;
            lane_ctrl[l] = 1'b1;
        end
        lane_data[start_lane] = `XGMII_START;
        for (int l = start_lane + 1; l < pos; l++) begin
            lane_ctrl[l] = 1'b0;
            if (l < start_lane + 7) begin
                lane_data[l] = 8'h55;
            end else if (l == start_lane + 7) begin
                lane_data[l] = 8'hD5;
            end else begin
                lane_data[l] = frame_bytes[l - start_lane - 8];
            end
        end
        lane_data[pos] = `XGMII_TERM;

        for (int w = 0; w < words; w++) begin
            for (int i = 0; i < 8; i++) begin
                data[i*8 +: 8] = lane_data[w*8 + i];
                ctrl[i]        = lane_ctrl[w*8 + i];
            end
            // Every word after the start word is one output beat
            if (w > 0) begin
                beat.keep = (w == 1 && start_lane == 4) ? 8'hF0 : 8'hFF;
                beat.last = (w == words - 1);
                if (beat.last) begin
                    beat.keep = beat.keep & 8'((1 << term_lane) - 1);
                end
                beat.data  = keep_bytes(data, beat.keep);
                beat.valid = 1'b1;
                beat.user  = beat.last && good;
                checker_i.push_expected(beat);
            end
            drive_word(data, ctrl);
        end
    endtask

    initial begin
        void'($urandom(32'h3da2));
        reset       = 1'b1;
        xgmii.data  = {8{`XGMII_IDLE}};
        xgmii.ctrl  = 8'hFF;
        xgmii.valid = 1'b0;
        @(negedge clk);
        xgmii.valid = 1'b1;
        repeat (RESET_CYCLES - 1) @(negedge clk);
        reset = 1'b0;

        repeat ($urandom_range(2, 5)) send_gap_word();
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame(f);
            repeat ($urandom_range(0, 3)) send_gap_word();
        end
        repeat (4) drive_word({8{`XGMII_IDLE}}, 8'hFF);
        @(negedge clk);

        checker_i.report_results(total_errors);
        if (total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Each frame with its gaps and pauses fits well inside 40 clocks
    initial begin
        #(RUN_LIMIT_NS);
        $display("Timeout: the run did not finish within %0d ns", RUN_LIMIT_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/eth_rx_pkg.sv
design/xgmii_lane_decoder.sv
design/rx_frame_ctrl.sv
design/rx_byte_masker.sv
design/crc32_slice8.sv
design/rx_fcs_check.sv
design/eth_rx_mac.sv
dv/eth_rx_checker.sv
dv/eth_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the receive MAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f sim.f --top-module eth_rx_tb \
    -Mdir "$BUILD_DIR" -o eth_rx_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/eth_rx_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
